// ==== common/carrierLoopPkg.sv ====
// Shared widths, register map and bus/configuration types for the carrier loop.
// Modules import this package in their body and use scoped names in port lists.

`default_nettype none

package carrierLoopPkg;

    // ------------------------------------------------------------
    // Data path widths
    // ------------------------------------------------------------
    localparam int errorWidth = 8;
    localparam int accumWidth = 40;
    localparam int freqWidth  = 32;
    localparam int expWidth   = 5;
    localparam int lockWidth  = 16;
    localparam int dataWidth  = 32;

    // ------------------------------------------------------------
    // Register space selected by addr[11:5] with the word in addr[4:0]
    // ------------------------------------------------------------
    localparam logic [6:0] loopSpaceBase = 7'h08;

    localparam logic [4:0] ctrlOffset   = 5'd0;
    localparam logic [4:0] gainOffset   = 5'd4;
    localparam logic [4:0] limitOffset  = 5'd8;
    localparam logic [4:0] lockOffset   = 5'd12;
    localparam logic [4:0] posDevOffset = 5'd16;
    localparam logic [4:0] negDevOffset = 5'd20;
    // Upper word of the integrator is read only
    localparam logic [4:0] accumOffset  = 5'd24;

    // Everything the loop blocks take from the register bank
    typedef struct packed {
        logic                  invertError;
        logic                  zeroError;
        logic                  clearAccum;
        logic [expWidth-1:0]   leadExp;
        logic [expWidth-1:0]   lagExp;
        logic [dataWidth-1:0]  limit;
        logic [lockWidth-1:0]  lockCount;
        logic [7:0]            syncThreshold;
        logic [freqWidth-1:0]  posDev;
        logic [freqWidth-1:0]  negDev;
    } loopConfig_t;

    // Single-cycle strobe bus with one write enable per byte lane
    typedef struct packed {
        logic [11:0]          addr;
        logic [dataWidth-1:0] din;
        logic [3:0]           byteWe;
    } regBus_t;

endpackage

`default_nettype wire

// ==== files.f ====
common/carrierLoopPkg.sv
loopFilter/lagIntegrator.sv
loopFilter/loopFilter.sv
source/loopRegs.sv
source/lockDetector.sv
source/deviationCorrector.sv
source/carrierLoop.sv
testbench/carrierLoopTb.sv

// ==== loopFilter/lagIntegrator.sv ====
// Integrating path of the loop filter.
// Accumulates the shifted error, clamps to +/- limit and clears on request.

`timescale 1ns/100ps
`default_nettype none

module lagIntegrator (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  loopEn,
    input  wire logic [carrierLoopPkg::errorWidth-1:0] loopError,
    input  wire logic [carrierLoopPkg::expWidth-1:0]   lagExp,
    input  wire logic [carrierLoopPkg::dataWidth-1:0]  limit,
    input  wire logic                                  clearAccum,
    output logic [carrierLoopPkg::accumWidth-1:0]      lagAccum
);

    import carrierLoopPkg::*;

    logic [accumWidth-1:0]        errorExt;
    logic [accumWidth-1:0]        lagTerm;
    // One guard bit so the sum cannot wrap before the clamp
    logic signed [accumWidth:0]   sumExt;
    logic signed [accumWidth:0]   upperLimit;
    logic signed [accumWidth:0]   lowerLimit;
    logic signed [accumWidth:0]   accumExt;

    assign errorExt = {{(accumWidth-errorWidth){loopError[errorWidth-1]}}, loopError};
    assign lagTerm  = errorExt << lagExp;

    // Limit field sits above 8 fractional bits
    assign upperLimit = {1'b0, limit, 8'h00};
    assign lowerLimit = -upperLimit;

    assign accumExt = {lagAccum[accumWidth-1], lagAccum};
    assign sumExt   = accumExt + {lagTerm[accumWidth-1], lagTerm};

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum <= '0;
        end else if (clearAccum) begin
            lagAccum <= '0;
        end else if (loopEn) begin
            if (sumExt > upperLimit) begin
                lagAccum <= upperLimit[accumWidth-1:0];
            end else if (sumExt < lowerLimit) begin
                lagAccum <= lowerLimit[accumWidth-1:0];
            end else begin
                lagAccum <= sumExt[accumWidth-1:0];
            end
        end
    end

    // After an update the integrator sits inside the range that applied to it
    assert property (@(posedge clk) disable iff (reset)
        loopEn |=> (accumExt <= $past(upperLimit)) && (accumExt >= $past(lowerLimit)));

endmodule

`default_nettype wire

// ==== loopFilter/loopFilter.sv ====
// Lead/lag loop filter of the carrier loop.
// Conditions the phase error, adds the lead term to the integrator and registers the sum.

`timescale 1ns/100ps
`default_nettype none

module loopFilter (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  loopEn,
    input  wire logic [carrierLoopPkg::errorWidth-1:0] phaseError,
    input  wire carrierLoopPkg::loopConfig_t           cfg,
    output logic [carrierLoopPkg::accumWidth-1:0]      lagAccum,
    output logic [carrierLoopPkg::accumWidth-1:0]      filterSum
);

    import carrierLoopPkg::*;

    logic [errorWidth-1:0] loopError;
    logic [errorWidth-1:0] conditionedError;
    logic [accumWidth-1:0] errorExt;
    logic [accumWidth-1:0] leadTerm;

    // ------------------------------------------------------------
    // Error conditioning where zeroing wins over inversion
    // ------------------------------------------------------------
    always_comb begin
        if (cfg.zeroError) begin
            conditionedError = '0;
        end else if (cfg.invertError) begin
            conditionedError = -phaseError;
        end else begin
            conditionedError = phaseError;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loopError <= '0;
        end else if (loopEn) begin
            loopError <= conditionedError;
        end
    end

    // ------------------------------------------------------------
    // Lead path
    // ------------------------------------------------------------
    assign errorExt = {{(accumWidth-errorWidth){loopError[errorWidth-1]}}, loopError};
    assign leadTerm = errorExt << cfg.leadExp;

    lagIntegrator lagPath (
        .clk        (clk),
        .reset      (reset),
        .loopEn     (loopEn),
        .loopError  (loopError),
        .lagExp     (cfg.lagExp),
        .limit      (cfg.limit),
        .clearAccum (cfg.clearAccum),
        .lagAccum   (lagAccum)
    );

    // Sum uses the integrator value from before this enable's update
    always_ff @(posedge clk) begin
        if (reset) begin
            filterSum <= '0;
        end else if (loopEn) begin
            filterSum <= lagAccum + leadTerm;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the carrier loop testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module carrierLoopTb -o carrierLoopSim

./obj_dir/carrierLoopSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "Run finished without errors"
    exit 0
else
    echo "Run reported errors, see sim.log"
    exit 1
fi

// ==== source/carrierLoop.sv ====
// Top level of the carrier recovery loop.
// Joins registers, loop filter, lock detector and deviation correction into the NCO word.

`timescale 1ns/100ps
`default_nettype none

module carrierLoop (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  loopEn,
    input  wire logic [carrierLoopPkg::errorWidth-1:0] phaseError,
    input  wire logic                                  sym2xEn,
    input  wire logic                                  legacyBit,
    input  wire carrierLoopPkg::regBus_t               bus,
    output logic [carrierLoopPkg::dataWidth-1:0]       dout,
    output logic [carrierLoopPkg::freqWidth-1:0]       ncoFreq,
    output logic                                       freqStrobe,
    output logic                                       carrierLock,
    output logic [carrierLoopPkg::lockWidth-1:0]       lockCounter
);

    import carrierLoopPkg::*;

    loopConfig_t           cfg;
    logic [accumWidth-1:0] lagAccum;
    logic [accumWidth-1:0] filterSum;
    logic [freqWidth-1:0]  deviationCorrection;

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------
    loopRegs regs (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .lagAccum (lagAccum),
        .dout     (dout),
        .cfg      (cfg)
    );

    loopFilter filter (
        .clk        (clk),
        .reset      (reset),
        .loopEn     (loopEn),
        .phaseError (phaseError),
        .cfg        (cfg),
        .lagAccum   (lagAccum),
        .filterSum  (filterSum)
    );

    lockDetector lockDet (
        .clk           (clk),
        .reset         (reset),
        .loopEn        (loopEn),
        .phaseError    (phaseError),
        .lockCount     (cfg.lockCount),
        .syncThreshold (cfg.syncThreshold),
        .lockCounter   (lockCounter),
        .carrierLock   (carrierLock)
    );

    deviationCorrector devCorr (
        .clk                 (clk),
        .reset               (reset),
        .sym2xEn             (sym2xEn),
        .legacyBit           (legacyBit),
        .posDev              (cfg.posDev),
        .negDev              (cfg.negDev),
        .deviationCorrection (deviationCorrection)
    );

    // ------------------------------------------------------------
    // NCO frequency word
    // ------------------------------------------------------------
    assign ncoFreq = filterSum[accumWidth-1 -: freqWidth] + deviationCorrection;

    // Filter sum is valid the cycle after the enable
    always_ff @(posedge clk) begin
        if (reset) begin
            freqStrobe <= 1'b0;
        end else begin
            freqStrobe <= loopEn;
        end
    end

endmodule

`default_nettype wire

// ==== source/deviationCorrector.sv ====
// Frequency deviation correction from pairs of legacy detector bits.
// Two equal bits pick posDev or negDev; the choice appears two sym2xEn later.

`timescale 1ns/100ps
`default_nettype none

module deviationCorrector (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire logic                                 sym2xEn,
    input  wire logic                                 legacyBit,
    input  wire logic [carrierLoopPkg::freqWidth-1:0] posDev,
    input  wire logic [carrierLoopPkg::freqWidth-1:0] negDev,
    output logic [carrierLoopPkg::freqWidth-1:0]      deviationCorrection
);

    import carrierLoopPkg::*;

    logic                 prevLegacyBit;
    logic [freqWidth-1:0] devCorrection;

    always_ff @(posedge clk) begin
        if (reset) begin
            prevLegacyBit       <= 1'b0;
            devCorrection       <= '0;
            deviationCorrection <= '0;
        end else if (sym2xEn) begin
            prevLegacyBit <= legacyBit;
            // A run of ones or zeros selects a correction
            if (legacyBit && prevLegacyBit) begin
                devCorrection <= posDev;
            end else if (!legacyBit && !prevLegacyBit) begin
                devCorrection <= negDev;
            end else begin
                devCorrection <= '0;
            end
            deviationCorrection <= devCorrection;
        end
    end

endmodule

`default_nettype wire

// ==== source/lockDetector.sv ====
// Carrier lock detector, an up/down counter driven by the phase error magnitude.
// Lock sets at the top of the count and clears at the bottom.

`timescale 1ns/100ps
`default_nettype none

module lockDetector (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  loopEn,
    input  wire logic [carrierLoopPkg::errorWidth-1:0] phaseError,
    input  wire logic [carrierLoopPkg::lockWidth-1:0]  lockCount,
    input  wire logic [7:0]                            syncThreshold,
    output logic [carrierLoopPkg::lockWidth-1:0]       lockCounter,
    output logic                                       carrierLock
);

    import carrierLoopPkg::*;

    // 8'h80 negates to itself, which reads as 128 unsigned
    logic [errorWidth-1:0] errorMag;
    logic                  errorLarge;

    assign errorMag   = phaseError[errorWidth-1] ? -phaseError : phaseError;
    assign errorLarge = errorMag > syncThreshold;

    always_ff @(posedge clk) begin
        if (reset) begin
            lockCounter <= '0;
            carrierLock <= 1'b0;
        end else if (loopEn) begin
            if (errorLarge) begin
                if (lockCounter == '0) begin
                    carrierLock <= 1'b0;
                    lockCounter <= lockCount;
                end else begin
                    lockCounter <= lockCounter - 1'b1;
                end
            end else begin
                if (lockCounter == '1) begin
                    carrierLock <= 1'b1;
                    lockCounter <= lockCount;
                end else begin
                    lockCounter <= lockCounter + 1'b1;
                end
            end
        end
    end

    // Lock state follows the loop enable
    assert property (@(posedge clk) disable iff (reset)
        !$stable(carrierLock) |-> $past(loopEn));

endmodule

`default_nettype wire

// ==== source/loopRegs.sv ====
// Configuration registers of the carrier loop with byte-lane writes.
// Read data is combinational from the address; the integrator word is read only.

`timescale 1ns/100ps
`default_nettype none

module loopRegs (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire carrierLoopPkg::regBus_t             bus,
    input  wire logic [carrierLoopPkg::accumWidth-1:0] lagAccum,
    output logic [carrierLoopPkg::dataWidth-1:0]     dout,
    output carrierLoopPkg::loopConfig_t              cfg
);

    import carrierLoopPkg::*;

    logic                  inSpace;
    logic                  wrEn;
    logic [4:0]            offset;
    logic [dataWidth-1:0]  ctrlReg;
    logic [dataWidth-1:0]  gainReg;
    logic [dataWidth-1:0]  limitReg;
    logic [dataWidth-1:0]  lockReg;
    logic [dataWidth-1:0]  posDevReg;
    logic [dataWidth-1:0]  negDevReg;

    // Replace only the lanes that are strobed
    function automatic logic [dataWidth-1:0] mergeBytes(
        input logic [dataWidth-1:0] oldWord,
        input logic [dataWidth-1:0] newWord,
        input logic [3:0]           we
    );
        logic [dataWidth-1:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign inSpace = (bus.addr[11:5] == loopSpaceBase);
    assign offset  = bus.addr[4:0];
    assign wrEn    = inSpace && (bus.byteWe != 4'h0);

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg   <= '0;
            gainReg   <= '0;
            limitReg  <= '0;
            lockReg   <= '0;
            posDevReg <= '0;
            negDevReg <= '0;
        end else if (wrEn) begin
            case (offset)
                ctrlOffset:   ctrlReg   <= mergeBytes(ctrlReg, bus.din, bus.byteWe);
                gainOffset:   gainReg   <= mergeBytes(gainReg, bus.din, bus.byteWe);
                limitOffset:  limitReg  <= mergeBytes(limitReg, bus.din, bus.byteWe);
                lockOffset:   lockReg   <= mergeBytes(lockReg, bus.din, bus.byteWe);
                posDevOffset: posDevReg <= mergeBytes(posDevReg, bus.din, bus.byteWe);
                negDevOffset: negDevReg <= mergeBytes(negDevReg, bus.din, bus.byteWe);
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (offset)
                ctrlOffset:   dout = ctrlReg;
                gainOffset:   dout = gainReg;
                limitOffset:  dout = limitReg;
                lockOffset:   dout = lockReg;
                posDevOffset: dout = posDevReg;
                negDevOffset: dout = negDevReg;
                accumOffset:  dout = lagAccum[accumWidth-1 -: dataWidth];
                default:      dout = '0;
            endcase
        end
    end

    // Field extraction
    assign cfg.invertError   = ctrlReg[0];
    assign cfg.zeroError     = ctrlReg[1];
    assign cfg.clearAccum    = ctrlReg[2];
    assign cfg.leadExp       = gainReg[4:0];
    assign cfg.lagExp        = gainReg[12:8];
    assign cfg.limit         = limitReg;
    assign cfg.lockCount     = lockReg[15:0];
    assign cfg.syncThreshold = lockReg[23:16];
    assign cfg.posDev        = posDevReg;
    assign cfg.negDev        = negDevReg;

    // A write aimed at the integrator word must leave the bank untouched
    assert property (@(posedge clk) disable iff (reset)
        (wrEn && offset == accumOffset) |=>
            $stable({ctrlReg, gainReg, limitReg, lockReg, posDevReg, negDevReg}));

endmodule

`default_nettype wire

// ==== testbench/carrierLoopTb.sv ====
// Table-driven testbench of the carrier loop with a reference model of the loop rules.
// Each row is a register write, a read, a loopEn pulse or a sym2xEn pulse, checked once applied.

`timescale 1ns/100ps
`default_nettype none

module carrierLoopTb;

    import carrierLoopPkg::*;

    localparam logic [1:0]  rowWrite     = 2'd0;
    localparam logic [1:0]  rowRead      = 2'd1;
    localparam logic [1:0]  rowLoop      = 2'd2;
    localparam logic [1:0]  rowSym       = 2'd3;
    localparam int          cyclesPerRow = 2;
    localparam logic [11:0] accumAddr    = {loopSpaceBase, accumOffset};

    typedef struct packed {
        logic [1:0]  kind;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  we;
        logic [7:0]  err;
        logic        legacy;
        logic        hasExp;
        logic [31:0] expData;
    } stimRow_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        loopEn;
    logic [7:0]  phaseError;
    logic        sym2xEn;
    logic        legacyBit;
    regBus_t     busIn;
    logic [31:0] dout;
    logic [31:0] ncoFreq;
    logic        freqStrobe;
    logic        carrierLock;
    logic [15:0] lockCounter;

    stimRow_t    rows[$];
    logic [31:0] lfsrState  = 32'h7e4a5ffa;
    int          errors     = 0;
    int          checks     = 0;
    int          cycleCount = 0;
    int          cycleLimit = 1000000;

    // ------------------------------------------------------------
    // Reference model state
    // ------------------------------------------------------------
    logic [31:0] mRegs [0:5];
    logic [7:0]  mLoopError;
    logic [39:0] mAccum;
    logic [39:0] mFilterSum;
    logic [15:0] mLockCounter;
    logic        mLock;
    logic        mPrevBit;
    logic [31:0] mDevNext;
    logic [31:0] mDevOut;
    logic        lockSeen;
    logic        lockLost;

    carrierLoop uut (
        .clk         (clk),
        .reset       (reset),
        .loopEn      (loopEn),
        .phaseError  (phaseError),
        .sym2xEn     (sym2xEn),
        .legacyBit   (legacyBit),
        .bus         (busIn),
        .dout        (dout),
        .ncoFreq     (ncoFreq),
        .freqStrobe  (freqStrobe),
        .carrierLock (carrierLock),
        .lockCounter (lockCounter)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout, the table did not finish within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomByte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrNext(lfsrState);
            b = {b[6:0], lfsrState[0]};
        end
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic pushRow(input logic [1:0] kind, input logic [11:0] addr,
                           input logic [31:0] data, input logic [3:0] we, input logic [7:0] err,
                           input logic legacy, input logic hasExp = 1'b0,
                           input logic [31:0] expData = '0);
        rows.push_back('{kind, addr, data, we, err, legacy, hasExp, expData});
    endtask

    // ------------------------------------------------------------
    // Model of the register bank and the loop
    // ------------------------------------------------------------
    task automatic storeWrite(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] we);
        if (addr[11:5] == loopSpaceBase && addr[1:0] == 2'b00 && addr[4:2] < 3'd6) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (we[lane]) begin
                    mRegs[addr[4:2]][8*lane +: 8] = data[8*lane +: 8];
                end
            end
        end
    endtask

    function automatic logic [31:0] expectedDout(input logic [11:0] addr);
        if (addr[11:5] != loopSpaceBase) begin
            return '0;
        end else if (addr[4:0] == 5'd24) begin
            return mAccum[39:8];
        end else if (addr[1:0] == 2'b00 && addr[4:2] < 3'd6) begin
            return mRegs[addr[4:2]];
        end
        return '0;
    endfunction

    task automatic stepLoopModel(input logic [7:0] e);
        logic [7:0]  mag;
        longint      lagSum;
        longint      bound;
        logic [63:0] leadTerm;
        // Sum takes the integrator before this update
        leadTerm   = longint'($signed(mLoopError)) <<< mRegs[1][4:0];
        mFilterSum = mAccum + leadTerm[39:0];
        bound      = longint'(mRegs[2]) * 256;
        lagSum     = longint'($signed(mAccum)) + (longint'($signed(mLoopError)) <<< mRegs[1][12:8]);
        if (mRegs[0][2]) begin
            mAccum = '0;
        end else if (lagSum > bound) begin
            mAccum = bound[39:0];
        end else if (lagSum < -bound) begin
            mAccum = 40'(-bound);
        end else begin
            mAccum = lagSum[39:0];
        end
        if (mRegs[0][1]) begin
            mLoopError = 8'h00;
        end else if (mRegs[0][0]) begin
            mLoopError = 8'h00 - e;
        end else begin
            mLoopError = e;
        end
        // Lock counter works on the raw error where 8'h80 counts as 128
        mag = e[7] ? 8'h00 - e : e;
        if (mag > mRegs[3][23:16]) begin
            if (mLockCounter == 16'h0000) begin
                lockLost     = lockLost | mLock;
                mLock        = 1'b0;
                mLockCounter = mRegs[3][15:0];
            end else begin
                mLockCounter = mLockCounter - 16'd1;
            end
        end else if (mLockCounter == 16'hFFFF) begin
            mLock        = 1'b1;
            lockSeen     = 1'b1;
            mLockCounter = mRegs[3][15:0];
        end else begin
            mLockCounter = mLockCounter + 16'd1;
        end
    endtask

    task automatic stepSymModel(input logic b);
        mDevOut  = mDevNext;
        mDevNext = (b && mPrevBit) ? mRegs[4] : (!b && !mPrevBit) ? mRegs[5] : 32'h0;
        mPrevBit = b;
    endtask

    // ------------------------------------------------------------
    // Each row takes two clock cycles
    // ------------------------------------------------------------
    task automatic applyRow(input stimRow_t r);
        logic [31:0] expNco;
        @(posedge clk);
        if (mRegs[0][2]) begin
            mAccum = '0;
        end
        #2;
        busIn.addr   = r.addr;
        busIn.din    = r.data;
        busIn.byteWe = (r.kind == rowWrite) ? r.we : 4'h0;
        loopEn       = (r.kind == rowLoop);
        sym2xEn      = (r.kind == rowSym);
        phaseError   = r.err;
        legacyBit    = r.legacy;
        @(posedge clk);
        case (r.kind)
            rowWrite: storeWrite(r.addr, r.data, r.we);
            rowLoop:  stepLoopModel(r.err);
            rowSym:   stepSymModel(r.legacy);
            default:  ;
        endcase
        #2;
        loopEn       = 1'b0;
        sym2xEn      = 1'b0;
        busIn.byteWe = 4'h0;
        @(negedge clk);
        // Frequency word wraps at 32 bits
        expNco = mFilterSum[39:8] + mDevOut;
        checkValue("freqStrobe", freqStrobe, r.kind == rowLoop);
        checkValue("ncoFreq", ncoFreq, expNco);
        checkValue("lockCounter", lockCounter, mLockCounter);
        checkValue("carrierLock", carrierLock, mLock);
        checkValue("dout", dout, expectedDout(r.addr));
        if (r.hasExp) begin
            checkValue("dout against table", dout, r.expData);
        end
    endtask

    task automatic buildTable();
        logic [7:0]  e;
        logic [12:0] symBits;
        logic [7:0]  smallErr [0:3];
        smallErr = '{8'h05, 8'hF8, 8'h0A, 8'hF6};
        symBits  = 13'b1100011010111;
        // Register bank with partial byte lanes
        pushRow(rowWrite, 12'h100, 32'hFFFF_FFF8, 4'b0010, 8'h00, 1'b0, 1'b1, 32'h0000_FF00);
        pushRow(rowWrite, 12'h104, 32'h1234_0A03, 4'b0011, 8'h00, 1'b0, 1'b1, 32'h0000_0A03);
        pushRow(rowWrite, 12'h108, 32'hA5A5_1234, 4'b0101, 8'h00, 1'b0, 1'b1, 32'h00A5_0034);
        pushRow(rowWrite, 12'h108, 32'h0F00_FF00, 4'b1010, 8'h00, 1'b0, 1'b1, 32'h0FA5_FF34);
        pushRow(rowWrite, 12'h10C, 32'hDEAD_BEEF, 4'b1100, 8'h00, 1'b0, 1'b1, 32'hDEAD_0000);
        pushRow(rowWrite, 12'h110, 32'h1122_3344, 4'b1000, 8'h00, 1'b0, 1'b1, 32'h1100_0000);
        pushRow(rowWrite, 12'h114, 32'h5566_7788, 4'b0110, 8'h00, 1'b0, 1'b1, 32'h0066_7700);
        pushRow(rowWrite, accumAddr, 32'hFFFF_FFFF, 4'hF, 8'h00, 1'b0, 1'b1, 32'h0);
        pushRow(rowWrite, 12'h208, 32'hFFFF_FFFF, 4'hF, 8'h00, 1'b0, 1'b1, 32'h0);
        pushRow(rowRead, 12'h108, 32'h0, 4'h0, 8'h00, 1'b0, 1'b1, 32'h0FA5_FF34);
        pushRow(rowRead, 12'h0E0, 32'h0, 4'h0, 8'h00, 1'b0, 1'b1, 32'h0);
        // Loop filter with random errors and no deviation
        pushRow(rowWrite, 12'h100, 32'h0, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h104, 32'h0000_0C04, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h108, 32'h0100_0000, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h10C, 32'h0, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h110, 32'h0, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h114, 32'h0, 4'hF, 8'h00, 1'b0);
        for (int i = 0; i < 38; i++) begin
            if (i == 24) begin
                pushRow(rowWrite, 12'h100, 32'h1, 4'hF, 8'h00, 1'b0);
            end else if (i == 32) begin
                pushRow(rowWrite, 12'h100, 32'h3, 4'hF, 8'h00, 1'b0);
            end
            randomByte(e);
            pushRow(rowLoop, accumAddr, 32'h0, 4'h0, e, 1'b0);
        end
        // Saturate at both limits and clear
        pushRow(rowWrite, 12'h100, 32'h0, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h108, 32'h0000_0100, 4'hF, 8'h00, 1'b0);
        for (int i = 0; i < 16; i++) begin
            pushRow(rowLoop, accumAddr, 32'h0, 4'h0, (i < 8) ? 8'h7F : 8'h80, 1'b0);
            if (i == 7) begin
                pushRow(rowRead, accumAddr, 32'h0, 4'h0, 8'h00, 1'b0, 1'b1, 32'h0000_0100);
            end
        end
        pushRow(rowRead, accumAddr, 32'h0, 4'h0, 8'h00, 1'b0, 1'b1, 32'hFFFF_FF00);
        pushRow(rowWrite, 12'h100, 32'h4, 4'hF, 8'h00, 1'b0);
        pushRow(rowRead, accumAddr, 32'h0, 4'h0, 8'h00, 1'b0, 1'b1, 32'h0);
        pushRow(rowWrite, 12'h100, 32'h0, 4'hF, 8'h00, 1'b0);
        // Lock up with small errors and lose lock after a short reload
        pushRow(rowWrite, 12'h10C, 32'h000A_FFF0, 4'hF, 8'h00, 1'b0);
        pushRow(rowLoop, accumAddr, 32'h0, 4'h0, 8'h90, 1'b0);
        pushRow(rowLoop, accumAddr, 32'h0, 4'h0, 8'h70, 1'b0);
        pushRow(rowLoop, accumAddr, 32'h0, 4'h0, 8'h80, 1'b0);
        for (int i = 0; i < 44; i++) begin
            if (i == 20) begin
                pushRow(rowWrite, 12'h10C, 32'h000A_0003, 4'hF, 8'h00, 1'b0);
            end
            e = (i < 36) ? smallErr[i % 4] : 8'hB0;
            pushRow(rowLoop, accumAddr, 32'h0, 4'h0, e, 1'b0);
        end
        // Deviation correction from legacy bit pairs
        pushRow(rowWrite, 12'h110, 32'h0012_3400, 4'hF, 8'h00, 1'b0);
        pushRow(rowWrite, 12'h114, 32'hFFF0_0000, 4'hF, 8'h00, 1'b0);
        for (int i = 12; i >= 0; i--) begin
            pushRow(rowSym, accumAddr, 32'h0, 4'h0, 8'h00, symBits[i]);
        end
        for (int i = 0; i < 4; i++) begin
            randomByte(e);
            pushRow(rowLoop, accumAddr, 32'h0, 4'h0, e, 1'b0);
        end
    endtask

    initial begin
        reset      = 1'b1;
        loopEn     = 1'b0;
        phaseError = 8'h00;
        sym2xEn    = 1'b0;
        legacyBit  = 1'b0;
        busIn      = '0;
        for (int i = 0; i < 6; i++) begin
            mRegs[i] = '0;
        end
        mLoopError   = '0;
        mAccum       = '0;
        mFilterSum   = '0;
        mLockCounter = '0;
        mLock        = 1'b0;
        mPrevBit     = 1'b0;
        mDevNext     = '0;
        mDevOut      = '0;
        lockSeen     = 1'b0;
        lockLost     = 1'b0;
        buildTable();
        cycleLimit = 2 * rows.size() * cyclesPerRow + 100;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        foreach (rows[i]) begin
            applyRow(rows[i]);
        end
        if (!lockSeen || !lockLost) begin
            errors++;
            $display("The lock test did not reach both lock and loss of lock");
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
